//--- tb.f
+incdir+.
rv_isa_pkg.sv
rv_bus_pkg.sv
control_unit.sv
alu.sv
branch_res.sv
rv32i_reg_file.sv
execute_stage.sv
apb_dmem.sv
exec_core.sv
tb_exec_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_exec_core -f tb.f -o tb_exec_core_sim
./obj_dir/tb_exec_core_sim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "run_sim: testbench reported failure"
  exit 1
fi
echo "run_sim: done"

//--- tb_exec_core.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_exec_core import rv_isa_pkg::*; ();

  localparam int N_INSTR        = 400;
  localparam int PRELOAD_WORDS  = 16;
  localparam int N_SETUP        = 3 + 3 * PRELOAD_WORDS;
  // every instruction fits in wait states plus setup, idle and accept
  localparam int TIMEOUT_CYCLES = N_INSTR * (`DMEM_WAIT_STATES + 4) + 20;

  // expected response for one accepted instruction
  typedef struct packed {
    word_t     brj_addr;
    logic      brj_taken;
    logic      mispredict;
    logic      illegal;
    logic      mal_load;
    logic      mal_store;
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;
  } expect_t;

  logic      CLK = 1'b0;
  logic      rst_n;
  logic      instr_valid;
  word_t     instr;
  word_t     pc;
  word_t     pc4;
  logic      prediction;
  logic      instr_ready;
  word_t     brj_addr;
  logic      brj_taken;
  logic      mispredict;
  logic      illegal_insn;
  logic      mal_load;
  logic      mal_store;
  logic      wb_en;
  reg_addr_t wb_rd;
  word_t     wb_data;
  logic      halt;

  // model state, byte memory wraps like the dut
  word_t      model_regs [`RV_REG_COUNT];
  logic [7:0] model_mem [`DMEM_DEPTH_WORDS * 4];
  expect_t    expd;

  logic [31:0] rng = 32'h3649_d328;
  int          accept_count = 0;
  int          check_count = 0;
  int          err_count = 0;
  int          cycle_count = 0;
  int          stall_count = 0;

  exec_core dut_i (
    .CLK(CLK), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr), .pc(pc),
    .pc4(pc4), .prediction(prediction), .instr_ready(instr_ready), .brj_addr(brj_addr),
    .brj_taken(brj_taken), .mispredict(mispredict), .illegal_insn(illegal_insn),
    .mal_load(mal_load), .mal_store(mal_store), .wb_en(wb_en), .wb_rd(wb_rd),
    .wb_data(wb_data), .halt(halt)
  );

  // 100 ns period
  always #50 CLK = ~CLK;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t rand_word();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic int mem_index(input word_t a);
    return int'(a % (`DMEM_DEPTH_WORDS * 4));
  endfunction

  // halfwords need even, words need four-byte addresses
  function automatic logic misaligned(input word_t addr, input logic [2:0] f3);
    case (f3[1:0])
      2'b00:   return 1'b0;
      2'b01:   return addr[0];
      default: return addr[1:0] != 2'b00;
    endcase
  endfunction

  // aligned loads and stores sit out idle, setup and the wait states
  function automatic int bus_stalls(input word_t insn, input expect_t e);
    logic [6:0] op;
    op = insn[6:0];
    if ((op == LOAD || op == STORE) && !e.mal_load && !e.mal_store) begin
      return `DMEM_WAIT_STATES + 2;
    end
    return 0;
  endfunction

  // rv32i arithmetic by funct3, alt is instruction bit 30
  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'h0, $signed(a) < $signed(b)};
      3'b011:  return {31'h0, a < b};
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // runs one instruction on the model and returns what the dut should show
  function automatic expect_t model_step(input word_t insn, input word_t ipc,
                                         input word_t ipc4, input logic pred);
    expect_t    e;
    logic [6:0] op;
    logic [2:0] f3;
    reg_addr_t  rd;
    word_t      a, b, imm_i, imm_s, imm_b, imm_u, imm_j, addr, data;
    logic       wen, taken;
    op    = insn[6:0];
    f3    = insn[14:12];
    rd    = insn[11:7];
    a     = model_regs[insn[19:15]];
    b     = model_regs[insn[24:20]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_u = {insn[31:12], 12'h000};
    imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    e          = '0;
    e.brj_addr = ipc4;
    e.wb_rd    = rd;
    wen        = 1'b0;
    case (op)
      LUI: begin
        e.wb_data = imm_u;
        wen       = 1'b1;
      end
      AUIPC: begin
        e.wb_data = ipc + imm_u;
        wen       = 1'b1;
      end
      JAL: begin
        e.brj_addr  = ipc + imm_j;
        e.brj_taken = 1'b1;
        e.wb_data   = ipc4;
        wen         = 1'b1;
      end
      JALR: begin
        data        = a + imm_i;
        e.brj_addr  = {data[31:1], 1'b0};
        e.brj_taken = 1'b1;
        e.wb_data   = ipc4;
        wen         = 1'b1;
      end
      BRANCH: begin
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          default: taken = (a >= b);
        endcase
        e.brj_taken = taken;
        if (taken) e.brj_addr = ipc + imm_b;
      end
      LOAD: begin
        addr       = a + imm_i;
        e.mal_load = misaligned(addr, f3);
        if (!e.mal_load) begin
          // little endian, lowest address in the low byte
          data = {model_mem[mem_index(addr + 3)], model_mem[mem_index(addr + 2)],
                  model_mem[mem_index(addr + 1)], model_mem[mem_index(addr)]};
          case (f3[1:0])
            2'b00:   e.wb_data = f3[2] ? {24'h0, data[7:0]} : {{24{data[7]}}, data[7:0]};
            2'b01:   e.wb_data = f3[2] ? {16'h0, data[15:0]} : {{16{data[15]}}, data[15:0]};
            default: e.wb_data = data;
          endcase
          wen = 1'b1;
        end
      end
      STORE: begin
        addr        = a + imm_s;
        e.mal_store = misaligned(addr, f3);
        if (!e.mal_store) begin
          model_mem[mem_index(addr)] = b[7:0];
          if (f3[1:0] != 2'b00) model_mem[mem_index(addr + 1)] = b[15:8];
          if (f3[1:0] == 2'b10) begin
            model_mem[mem_index(addr + 2)] = b[23:16];
            model_mem[mem_index(addr + 3)] = b[31:24];
          end
        end
      end
      IMMED: begin
        // bit 30 only selects srai among the immediate forms
        e.wb_data = alu_ref(f3, (f3 == 3'b101) && insn[30], a, imm_i);
        wen       = 1'b1;
      end
      REGREG: begin
        e.wb_data = alu_ref(f3, insn[30], a, b);
        wen       = 1'b1;
      end
      // ecall and ebreak only stop the core
      SYSTEM: wen = 1'b0;
      default: e.illegal = 1'b1;
    endcase
    e.mispredict = (op == JAL || op == JALR || op == BRANCH) && (pred ^ e.brj_taken);
    e.wb_en      = wen && (rd != 5'd0);
    if (e.wb_en) model_regs[rd] = e.wb_data;
    return e;
  endfunction

  // one random instruction from the kept opcode set
  function automatic word_t random_insn();
    word_t      r, s;
    reg_addr_t  rd, base;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [5:0] off;
    logic [11:0] imm12;
    r  = rand_word();
    s  = rand_word();
    // x5..x7 hold bases and preload data, x0 shows up now and then
    rd = (s[4:0] >= 5'd8) ? s[4:0] : ((s[7:5] == 3'd0) ? 5'd0 : {2'b01, s[7:5]});
    f3 = s[14:12];
    // load and store addresses stay inside the preloaded window
    off = r[25:20];
    if (r[27:26] != 2'b00) begin
      if (f3[1:0] == 2'b01) off[0] = 1'b0;
      if (f3[1:0] >= 2'b10) off[1:0] = 2'b00;
    end
    base  = r[28] ? 5'd6 : 5'd5;
    imm12 = r[28] ? 12'(off) - 12'd32 : 12'(off);
    case (r[3:0])
      4'd0, 4'd1: begin
        f7 = (s[15] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000;
        return {f7, s[24:20], s[19:15], f3, rd, REGREG};
      end
      4'd2, 4'd3: begin
        if (f3 == 3'b001) return {7'b0000000, s[24:20], s[19:15], f3, rd, IMMED};
        if (f3 == 3'b101) begin
          f7 = s[15] ? 7'b0100000 : 7'b0000000;
          return {f7, s[24:20], s[19:15], f3, rd, IMMED};
        end
        return {r[31:20], s[19:15], f3, rd, IMMED};
      end
      4'd4: return {r[31:12], rd, LUI};
      4'd5: return {r[31:12], rd, AUIPC};
      4'd6: return {r[31:12], rd, JAL};
      4'd7: return {r[31:20], s[19:15], 3'b000, rd, JALR};
      4'd8, 4'd9: begin
        // 010 and 011 are not branches
        if (f3[2:1] == 2'b01) f3 = {1'b1, f3[1:0]};
        return {r[31:25], s[24:20], s[19:15], f3, r[11:7], BRANCH};
      end
      4'd10, 4'd11, 4'd12: begin
        if (f3 == 3'b011 || f3[2:1] == 2'b11) f3 = f3 - 3'd2;
        return {imm12, base, f3, rd, LOAD};
      end
      4'd13, 4'd14: begin
        f3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
        return {imm12[11:5], s[24:20], base, f3, imm12[4:0], STORE};
      end
      // custom-0 opcode, undefined for this core
      default: return {r[31:7], 7'b0001011};
    endcase
  endfunction

  task automatic check(input string what, input word_t got, input word_t want);
    check_count = check_count + 1;
    if (got !== want) begin
      err_count = err_count + 1;
      $display("FAILED at %0t ns: %s for insn %h, got %h expected %h",
               $time, what, instr, got, want);
    end
  endtask

  // presents one instruction and holds it until the dut takes it
  task automatic issue(input word_t insn);
    int    target;
    word_t r;
    target      = accept_count + 1;
    r           = rand_word();
    instr       = insn;
    pc          = {r[31:2], 2'b00};
    pc4         = {r[31:2], 2'b00} + 32'd4;
    prediction  = r[1];
    instr_valid = 1'b1;
    while (accept_count < target) begin
      @(posedge CLK);
    end
    #1;
  endtask

  // outputs are settled by the falling edge before the accepting edge
  always @(negedge CLK) begin
    if (rst_n && instr_valid && instr_ready) begin
      expd = model_step(instr, pc, pc4, prediction);
      check("brj_addr", brj_addr, expd.brj_addr);
      check("brj_taken", 32'(brj_taken), 32'(expd.brj_taken));
      check("mispredict", 32'(mispredict), 32'(expd.mispredict));
      check("illegal_insn", 32'(illegal_insn), 32'(expd.illegal));
      check("mal_load", 32'(mal_load), 32'(expd.mal_load));
      check("mal_store", 32'(mal_store), 32'(expd.mal_store));
      check("wb_en", 32'(wb_en), 32'(expd.wb_en));
      if (expd.wb_en) begin
        check("wb_rd", 32'(wb_rd), 32'(expd.wb_rd));
        check("wb_data", wb_data, expd.wb_data);
      end
      // cycles the instruction waited with instr_ready low
      check("stall cycles", stall_count, bus_stalls(instr, expd));
      stall_count  = 0;
      accept_count = accept_count + 1;
    end else if (rst_n && instr_valid) begin
      stall_count = stall_count + 1;
    end
  end

  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles, %0d instructions accepted",
               TIMEOUT_CYCLES, accept_count);
      $display("errors: %0d mismatches in %0d checks, plus the timeout",
               err_count, check_count);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    word_t       r;
    logic [11:0] imm12;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    pc4         = 32'd4;
    prediction  = 1'b0;
    for (int i = 0; i < `RV_REG_COUNT; i++) begin
      model_regs[i] = '0;
    end
    repeat (4) @(posedge CLK);
    #1 rst_n = 1'b1;

    // idle state before any instruction
    @(negedge CLK);
    check("instr_ready after reset", 32'(instr_ready), 32'd1);
    check("halt after reset", 32'(halt), 32'd0);
    check("wb_en after reset", 32'(wb_en), 32'd0);
    check("brj_taken after reset", 32'(brj_taken), 32'd0);
    check("mispredict after reset", 32'(mispredict), 32'd0);
    check("illegal_insn after reset", 32'(illegal_insn), 32'd0);
    check("mal_load after reset", 32'(mal_load), 32'd0);
    check("mal_store after reset", 32'(mal_store), 32'd0);
    @(posedge CLK);
    #1;

    // x5 = 0x200, x6 = 0x220 through lui and addi
    issue({12'h200, 5'd0, 3'b000, 5'd5, IMMED});
    issue({20'h00000, 5'd6, LUI});
    issue({12'h220, 5'd6, 3'b000, 5'd6, IMMED});
    // fill the load window so no load returns unknown bytes
    for (int i = 0; i < PRELOAD_WORDS; i++) begin
      r     = rand_word();
      imm12 = 12'(4 * i);
      issue({r[31:12], 5'd7, LUI});
      issue({r[11:0], 5'd7, 3'b000, 5'd7, IMMED});
      issue({imm12[11:5], 5'd7, 5'd5, 3'b010, imm12[4:0], STORE});
    end
    for (int i = 0; i < N_INSTR - N_SETUP - 1; i++) begin
      issue(random_insn());
    end
    issue(EBREAK_INSN);

    // keep offering an addi, the halted core must not take it
    instr = {12'h001, 5'd0, 3'b000, 5'd8, IMMED};
    repeat (8) begin
      @(negedge CLK);
      check("halt", 32'(halt), 32'd1);
      check("instr_ready while halted", 32'(instr_ready), 32'd0);
    end
    check("accepted instruction count", accept_count, N_INSTR);

    $display("errors: %0d mismatches in %0d checks", err_count, check_count);
    if (err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- exec_core.sv
`timescale 1ns/1ps

module exec_core import rv_isa_pkg::*; import rv_bus_pkg::*; (
  input  logic      CLK,
  input  logic      rst_n,
  input  logic      instr_valid,
  input  word_t     instr,
  input  word_t     pc,
  input  word_t     pc4,
  input  logic      prediction,
  output logic      instr_ready,
  output word_t     brj_addr,
  output logic      brj_taken,
  output logic      mispredict,
  output logic      illegal_insn,
  output logic      mal_load,
  output logic      mal_store,
  output logic      wb_en,
  output reg_addr_t wb_rd,
  output word_t     wb_data,
  output logic      halt
);

  // data side apb wires
  logic     psel, penable, pwrite, pready;
  word_t    paddr, pwdata, prdata;
  byte_en_t pstrb;

  execute_stage ex (
    .CLK(CLK), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr), .pc(pc),
    .pc4(pc4), .prediction(prediction), .instr_ready(instr_ready), .brj_addr(brj_addr),
    .brj_taken(brj_taken), .mispredict(mispredict), .illegal_insn(illegal_insn),
    .mal_load(mal_load), .mal_store(mal_store), .wb_en(wb_en), .wb_rd(wb_rd),
    .wb_data(wb_data), .halt(halt), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready)
  );

  apb_dmem dmem (
    .CLK(CLK), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready)
  );

endmodule

//--- apb_dmem.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module apb_dmem import rv_isa_pkg::*; import rv_bus_pkg::*; (
  input  logic     CLK,
  input  logic     rst_n,
  input  logic     psel,
  input  logic     penable,
  input  logic     pwrite,
  input  word_t    paddr,
  input  word_t    pwdata,
  input  byte_en_t pstrb,
  output word_t    prdata,
  output logic     pready
);

  localparam int IDX_W = $clog2(`DMEM_DEPTH_WORDS);
  localparam int CNT_W = $clog2(`DMEM_WAIT_STATES + 2);

  word_t             mem [`DMEM_DEPTH_WORDS];
  logic [IDX_W-1:0]  idx;
  logic [CNT_W-1:0]  wait_cnt;
  logic              access;

  // word address wraps at the memory depth
  assign idx    = paddr[2 +: IDX_W];
  assign access = psel && penable;
  assign pready = access && (wait_cnt == CNT_W'(`DMEM_WAIT_STATES));
  assign prdata = mem[idx];

  // counts stalled access cycles
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt <= '0;
    end else if (access && !pready) begin
      wait_cnt <= wait_cnt + 1'b1;
    end else begin
      wait_cnt <= '0;
    end
  end

  // strobed bytes land on the completing edge
  always_ff @(posedge CLK) begin
    if (access && pready && pwrite) begin
      for (int i = 0; i < 4; i++) begin
        if (pstrb[i]) mem[idx][8*i +: 8] <= pwdata[8*i +: 8];
      end
    end
  end

  a_paddr_stable: assert property (@(posedge CLK) disable iff (!rst_n)
    (access && !pready) |=> $stable(paddr));

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage import rv_isa_pkg::*; import rv_bus_pkg::*; (
  input  logic      CLK,
  input  logic      rst_n,
  input  logic      instr_valid,
  input  word_t     instr,
  input  word_t     pc,
  input  word_t     pc4,
  input  logic      prediction,
  output logic      instr_ready,
  output word_t     brj_addr,
  output logic      brj_taken,
  output logic      mispredict,
  output logic      illegal_insn,
  output logic      mal_load,
  output logic      mal_store,
  output logic      wb_en,
  output reg_addr_t wb_rd,
  output word_t     wb_data,
  output logic      halt,
  output logic      psel,
  output logic      penable,
  output logic      pwrite,
  output word_t     paddr,
  output word_t     pwdata,
  output byte_en_t  pstrb,
  input  word_t     prdata,
  input  logic      pready
);

  alu_op_t      alu_op;
  logic [1:0]   alu_a_sel, alu_b_sel;
  wsel_t        w_sel;
  logic         cu_wen, dren, dwen, jump, j_sel, branch, halt_insn, illegal;
  load_type_t   load_type;
  branch_type_t branch_type;
  word_t        imm;
  reg_addr_t    rs1, rs2, rd;
  word_t        rs1_data, rs2_data, w_data;
  word_t        port_a, port_b, alu_out;
  logic         branch_taken;
  word_t        branch_addr;
  word_t        jump_base, jump_sum;
  logic [1:0]   byte_offset;
  byte_en_t     byte_en;
  logic         mal_addr, mem_op, accept, rf_wen, halt_q;
  word_t        dload_ext;
  logic [7:0]   load_byte;
  logic [15:0]  load_half;
  apb_state_t   state, next_state;

  control_unit cu (
    .instr(instr), .alu_op(alu_op), .alu_a_sel(alu_a_sel), .alu_b_sel(alu_b_sel),
    .w_sel(w_sel), .wen(cu_wen), .dren(dren), .dwen(dwen), .jump(jump), .j_sel(j_sel),
    .branch(branch), .halt_insn(halt_insn), .illegal(illegal), .load_type(load_type),
    .branch_type(branch_type), .imm(imm), .rs1(rs1), .rs2(rs2), .rd(rd)
  );

  rv32i_reg_file rf (
    .CLK(CLK), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd(rd), .wen(rf_wen),
    .w_data(w_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  alu alu_i (.aluop(alu_op), .port_a(port_a), .port_b(port_b), .port_out(alu_out));

  branch_res br (
    .rs1_data(rs1_data), .rs2_data(rs2_data), .pc(pc), .imm_sb(imm),
    .branch_type(branch_type), .branch_taken(branch_taken), .branch_addr(branch_addr)
  );

  // operand a is rs1, or pc for auipc
  always_comb begin
    case (alu_a_sel)
      2'd0:    port_a = rs1_data;
      2'd1:    port_a = pc;
      default: port_a = '0;
    endcase
  end

  // operand b is rs2 for register ops, else the decoded immediate
  always_comb begin
    case (alu_b_sel)
      2'd0:    port_b = rs1_data;
      2'd1:    port_b = rs2_data;
      default: port_b = imm;
    endcase
  end

  // one adder for jal and jalr, bit 0 cleared for jalr
  assign jump_base = j_sel ? pc : rs1_data;
  assign jump_sum  = jump_base + imm;

  always_comb begin
    if (jump) begin
      brj_addr = {jump_sum[31:1], 1'b0};
    end else if (branch && branch_taken) begin
      brj_addr = branch_addr;
    end else begin
      brj_addr = pc4;
    end
  end

  assign brj_taken  = instr_valid && (jump || (branch && branch_taken));
  // prediction only matters for control transfers
  assign mispredict = instr_valid && (jump || branch) && (prediction ^ brj_taken);

  // lanes and alignment from width and low address bits
  assign byte_offset = alu_out[1:0];

  always_comb begin
    byte_en  = 4'b0000;
    mal_addr = 1'b0;
    case (load_type)
      LB, LBU: byte_en = 4'b0001 << byte_offset;
      LH, LHU: begin
        byte_en  = byte_offset[1] ? 4'b1100 : 4'b0011;
        mal_addr = byte_offset[0];
      end
      LW: begin
        byte_en  = 4'b1111;
        mal_addr = (byte_offset != 2'b00);
      end
      default: byte_en = 4'b0000;
    endcase
  end

  assign illegal_insn = instr_valid && illegal;
  assign mal_load     = instr_valid && dren && mal_addr;
  assign mal_store    = instr_valid && dwen && mal_addr;

  // an aligned load or store needs the bus
  assign mem_op = instr_valid && !halt_q && (dren || dwen) && !mal_addr;

  always_comb begin
    next_state = state;
    case (state)
      IDLE:    if (mem_op) next_state = SETUP;
      SETUP:   next_state = ACCESS;
      ACCESS:  if (pready) next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // address and data come straight from the held instruction
  assign psel    = (state == SETUP) || (state == ACCESS);
  assign penable = (state == ACCESS);
  assign pwrite  = dwen;
  assign paddr   = alu_out;
  assign pstrb   = dwen ? byte_en : 4'b0000;

  // store data copied to every lane so the strobe picks the right one
  always_comb begin
    case (load_type)
      LB:      pwdata = {4{rs2_data[7:0]}};
      LH:      pwdata = {2{rs2_data[15:0]}};
      default: pwdata = rs2_data;
    endcase
  end

  // memory ops finish with pready, everything else in idle
  always_comb begin
    if (halt_q) begin
      instr_ready = 1'b0;
    end else if (state == IDLE) begin
      instr_ready = !mem_op;
    end else begin
      instr_ready = (state == ACCESS) && pready;
    end
  end

  assign accept = instr_valid && instr_ready;

  // load data picked by offset then extended by width
  assign load_byte = prdata[8*byte_offset +: 8];
  assign load_half = prdata[16*byte_offset[1] +: 16];

  always_comb begin
    case (load_type)
      LB:      dload_ext = {{24{load_byte[7]}}, load_byte};
      LBU:     dload_ext = {24'b0, load_byte};
      LH:      dload_ext = {{16{load_half[15]}}, load_half};
      LHU:     dload_ext = {16'b0, load_half};
      default: dload_ext = prdata;
    endcase
  end

  always_comb begin
    case (w_sel)
      W_LOAD:  w_data = dload_ext;
      W_PC4:   w_data = pc4;
      W_IMM_U: w_data = imm;
      default: w_data = alu_out;
    endcase
  end

  // register write only on the accepting edge
  assign rf_wen  = cu_wen && accept && !(dren && mal_addr);
  assign wb_en   = rf_wen && (rd != '0);
  assign wb_rd   = rd;
  assign wb_data = w_data;

  // halt is sticky until reset
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      halt_q <= 1'b0;
    end else if (accept && halt_insn) begin
      halt_q <= 1'b1;
    end
  end

  assign halt = halt_q;

  // once selected the requester stays on the bus until the completer is ready
  a_psel_held: assert property (@(posedge CLK) disable iff (!rst_n)
    (psel && !(penable && pready)) |=> psel);

  // access phase only after a setup cycle with psel already high
  a_penable_psel: assert property (@(posedge CLK) disable iff (!rst_n)
    penable |-> (psel && $past(psel)));

endmodule

//--- rv32i_reg_file.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv32i_reg_file import rv_isa_pkg::*; (
  input  logic      CLK,
  input  logic      rst_n,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t rd,
  input  logic      wen,
  input  word_t     w_data,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [`RV_REG_COUNT];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      // x0 is never written
      regs[rd] <= w_data;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 reads back as zero whenever a port selects it
  a_x0_zero: assert property (@(posedge CLK) disable iff (!rst_n)
    (rs1 == '0) |-> (rs1_data == '0));

endmodule

//--- branch_res.sv
`timescale 1ns/1ps

module branch_res import rv_isa_pkg::*; (
  input  word_t        rs1_data,
  input  word_t        rs2_data,
  input  word_t        pc,
  input  word_t        imm_sb,
  input  branch_type_t branch_type,
  output logic         branch_taken,
  output word_t        branch_addr
);

  logic eq, lt_s, lt_u;

  assign eq   = (rs1_data == rs2_data);
  assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
  assign lt_u = (rs1_data < rs2_data);

  always_comb begin
    case (branch_type)
      BEQ:  branch_taken = eq;
      BNE:  branch_taken = !eq;
      BLT:  branch_taken = lt_s;
      BGE:  branch_taken = !lt_s;
      BLTU: branch_taken = lt_u;
      BGEU: branch_taken = !lt_u;
      default: branch_taken = 1'b0;
    endcase
  end

  // target is relative to the branch itself
  assign branch_addr = pc + imm_sb;

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu import rv_isa_pkg::*; (
  input  alu_op_t aluop,
  input  word_t   port_a,
  input  word_t   port_b,
  output word_t   port_out
);

  logic [4:0] shamt;

  // shift amount is the low five bits only
  assign shamt = port_b[4:0];

  always_comb begin
    case (aluop)
      ADD:  port_out = port_a + port_b;
      SUB:  port_out = port_a - port_b;
      SLL:  port_out = port_a << shamt;
      SRL:  port_out = port_a >> shamt;
      // arithmetic shift keeps the sign
      SRA:  port_out = $signed(port_a) >>> shamt;
      SLT:  port_out = {31'b0, $signed(port_a) < $signed(port_b)};
      SLTU: port_out = {31'b0, port_a < port_b};
      XOR:  port_out = port_a ^ port_b;
      OR:   port_out = port_a | port_b;
      AND:  port_out = port_a & port_b;
      default: port_out = '0;
    endcase
  end

endmodule

//--- control_unit.sv
`timescale 1ns/1ps

module control_unit import rv_isa_pkg::*; (
  input  word_t        instr,
  output alu_op_t      alu_op,
  output logic [1:0]   alu_a_sel,
  output logic [1:0]   alu_b_sel,
  output wsel_t        w_sel,
  output logic         wen,
  output logic         dren,
  output logic         dwen,
  output logic         jump,
  output logic         j_sel,
  output logic         branch,
  output logic         halt_insn,
  output logic         illegal,
  output load_type_t   load_type,
  output branch_type_t branch_type,
  output word_t        imm,
  output reg_addr_t    rs1,
  output reg_addr_t    rs2,
  output reg_addr_t    rd
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd  = instr[11:7];

  // funct3 sits in the same place for loads, stores and branches
  assign load_type   = load_type_t'(funct3);
  assign branch_type = branch_type_t'(funct3);

  // immediates per format, all sign-extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    // defaults describe a harmless no-op
    alu_op    = ADD;
    alu_a_sel = 2'd0;
    alu_b_sel = 2'd2;
    w_sel     = W_ALU;
    wen       = 1'b0;
    dren      = 1'b0;
    dwen      = 1'b0;
    jump      = 1'b0;
    j_sel     = 1'b0;
    branch    = 1'b0;
    halt_insn = 1'b0;
    illegal   = 1'b0;
    imm       = imm_i;
    case (opcode)
      LUI: begin
        imm   = imm_u;
        w_sel = W_IMM_U;
        wen   = 1'b1;
      end
      AUIPC: begin
        // pc plus upper immediate through the alu
        imm       = imm_u;
        alu_a_sel = 2'd1;
        wen       = 1'b1;
      end
      JAL: begin
        imm   = imm_j;
        jump  = 1'b1;
        j_sel = 1'b1;
        w_sel = W_PC4;
        wen   = 1'b1;
      end
      JALR: begin
        jump    = 1'b1;
        w_sel   = W_PC4;
        wen     = 1'b1;
        illegal = (funct3 != 3'b000);
      end
      BRANCH: begin
        imm     = imm_b;
        branch  = 1'b1;
        illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      LOAD: begin
        dren    = 1'b1;
        w_sel   = W_LOAD;
        wen     = 1'b1;
        illegal = (funct3 == 3'b011) || (funct3 == 3'b110) || (funct3 == 3'b111);
      end
      STORE: begin
        imm     = imm_s;
        dwen    = 1'b1;
        illegal = (funct3 > 3'b010);
      end
      IMMED, REGREG: begin
        wen = 1'b1;
        if (opcode == REGREG) begin
          alu_b_sel = 2'd1;
        end
        case (funct3)
          3'b000: alu_op = (opcode == REGREG && funct7 == FUNCT7_ALT) ? SUB : ADD;
          3'b001: alu_op = SLL;
          3'b010: alu_op = SLT;
          3'b011: alu_op = SLTU;
          3'b100: alu_op = XOR;
          3'b101: alu_op = (funct7 == FUNCT7_ALT) ? SRA : SRL;
          3'b110: alu_op = OR;
          default: alu_op = AND;
        endcase
        // funct7 only matters for shifts and register ops
        if (opcode == REGREG || funct3 == 3'b001 || funct3 == 3'b101) begin
          illegal = !(funct7 == 7'b0 ||
                      (funct7 == FUNCT7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)));
          if (opcode == IMMED && funct3 == 3'b001 && funct7 != 7'b0) begin
            illegal = 1'b1;
          end
        end
      end
      SYSTEM: begin
        // no csr support, anything but ecall or ebreak is illegal
        halt_insn = (instr == ECALL_INSN) || (instr == EBREAK_INSN);
        illegal   = !halt_insn;
      end
      default: illegal = 1'b1;
    endcase
    // an illegal instruction must not touch state
    if (illegal) begin
      wen  = 1'b0;
      dren = 1'b0;
      dwen = 1'b0;
    end
  end

endmodule

//--- rv_bus_pkg.sv
package rv_bus_pkg;

  // one bit per byte lane, bit 0 is the lowest address
  typedef logic [3:0] byte_en_t;

  // APB requester phases
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SETUP  = 2'd1,
    ACCESS = 2'd2
  } apb_state_t;

endpackage

//--- rv_isa_pkg.sv
package rv_isa_pkg;

  // data, address and pc width
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // major opcodes handled by the execute stage
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    IMMED  = 7'b0010011,
    REGREG = 7'b0110011,
    SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } alu_op_t;

  // funct3 of loads, reused as the store width
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_type_t;

  // funct3 of conditional branches
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_type_t;

  // write-back source
  typedef enum logic [2:0] {
    W_LOAD  = 3'd0,
    W_PC4   = 3'd1,
    W_IMM_U = 3'd2,
    W_ALU   = 3'd3
  } wsel_t;

  // the only two SYSTEM encodings this core knows
  localparam word_t ECALL_INSN  = 32'h0000_0073;
  localparam word_t EBREAK_INSN = 32'h0010_0073;

  // funct7 that flips ADD to SUB and SRL to SRA
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

endpackage

//--- rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// architectural register count
`define RV_REG_COUNT 32

// data memory size in 32-bit words, kept a power of two
`define DMEM_DEPTH_WORDS 256

// low-pready cycles the data memory inserts in every access phase
`define DMEM_WAIT_STATES 2

`endif
